//--- design/nibble_bus_pkg.sv
`default_nettype none

// definitions shared by everything that sits on the nibble-wide system bus
package nibble_bus_pkg;

	// width of a bus address, the whole map is 2^20 nibbles
	localparam int unsigned BUS_ADDR_W = 20;

	// command codes seen by every device on the bus
	// codes 9 to 15 are undefined and make a device flag an error
	typedef enum logic [3:0] {
		NOP       = 4'h0,
		PC_READ   = 4'h1,
		PC_WRITE  = 4'h2,
		DP_READ   = 4'h3,
		DP_WRITE  = 4'h4,
		LOAD_PC   = 4'h5,
		LOAD_DP   = 4'h6,
		CONFIGURE = 4'h7,
		BUS_RESET = 4'h8
	} bus_op_t;

	typedef logic [3:0] nibble_t;
	typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

	// a region length needs one more bit, since a region may span the whole map
	typedef logic [BUS_ADDR_W:0] bus_len_t;
	localparam bus_len_t ADDR_SPACE = bus_len_t'(1) << BUS_ADDR_W;

	// one broadcast from the bridge to all devices
	typedef struct packed {
		bus_op_t   op;
		bus_addr_t addr;
		nibble_t   nibble;
	} bus_cmd_t;

	// what a single device answers, one cycle after the command
	typedef struct packed {
		logic    hit;
		nibble_t nibble;
		logic    error;
	} bank_resp_t;

endpackage

`default_nettype wire

//--- design/mem_sys_pkg.sv
`default_nettype none

// sizing of the memory subsystem and the host register map
package mem_sys_pkg;

	// number of RAM banks on the daisy chain
	localparam int unsigned NUM_BANKS = 3;

	// nibbles actually stored in one bank
	localparam int unsigned BANK_DEPTH = 64;

	// index width into the storage of one bank
	localparam int unsigned BANK_ADDR_W = $clog2(BANK_DEPTH);

	// host word addresses on the Wishbone port
	// the command register is write only and the status register read only
	typedef enum logic [0:0] {
		CMD_REG    = 1'b0,
		STATUS_REG = 1'b1
	} host_reg_t;

endpackage

`default_nettype wire

//--- design/wb_bus_bridge.sv
`timescale 1ns/1ps
`default_nettype none

// Wishbone classic slave in front of the nibble bus
// a write to the command register becomes exactly one bus command, and the
// status register holds what the banks returned for the last read
module wb_bus_bridge (
	input logic strobe,
	input logic rst_n,
	input logic cyc,
	input logic stb,
	input logic we,
	input mem_sys_pkg::host_reg_t adr,
	input logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic ack,
	output nibble_bus_pkg::bus_cmd_t cmd,
	input nibble_bus_pkg::bank_resp_t merged,
	input logic conflict
);
	import nibble_bus_pkg::*;
	import mem_sys_pkg::*;

	// ISSUE is the single cycle in which cmd carries a real command
	// CAPTURE waits for the registered bank response of a read
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		CAPTURE,
		ACK
	} state_t;

	// status register, laid out so it drops straight into dat_r[6:0]
	typedef struct packed {
		logic    error;
		logic    conflict;
		logic    hit;
		nibble_t nibble;
	} status_t;

	state_t state;
	status_t status;
	logic issue_is_read;

	// a read opcode needs the extra capture cycle before ack
	assign issue_is_read = (cmd.op == PC_READ) || (cmd.op == DP_READ);

	always_ff @(posedge strobe or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			ack <= 1'b0;
			dat_r <= '0;
			status <= '0;
			cmd <= '{op: NOP, addr: '0, nibble: '0};
		end else begin
			case (state)
			IDLE: begin
				// the host holds cyc and stb until ack, so a new access
				// is only seen here once the previous one has finished
				if (cyc && stb) begin
					if (we && (adr == CMD_REG)) begin
						cmd.op <= bus_op_t'(dat_w[3:0]);
						cmd.nibble <= dat_w[7:4];
						cmd.addr <= dat_w[27:8];
						state <= ISSUE;
					end else begin
						// status read answers at once
						// a write to the status register is acked and ignored
						// and a read of the command register returns zero
						if (!we && (adr == STATUS_REG)) begin
							dat_r <= {25'b0, status};
						end else begin
							dat_r <= '0;
						end
						ack <= 1'b1;
						state <= ACK;
					end
				end
			end
			ISSUE: begin
				// the command was on the bus for this one cycle only
				cmd <= '{op: NOP, addr: '0, nibble: '0};
				if (issue_is_read) begin
					state <= CAPTURE;
				end else begin
					ack <= 1'b1;
					state <= ACK;
				end
			end
			CAPTURE: begin
				// banks registered their answer at the end of ISSUE
				status.nibble <= merged.nibble;
				status.hit <= merged.hit;
				status.conflict <= conflict;
				status.error <= merged.error;
				ack <= 1'b1;
				state <= ACK;
			end
			ACK: begin
				// error is sticky in the banks, so picking it up here once
				// per access keeps the status bit current after any command
				status.error <= merged.error;
				ack <= 1'b0;
				state <= IDLE;
			end
			default: begin
				ack <= 1'b0;
				state <= IDLE;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/nibble_ram_bank.sv
`timescale 1ns/1ps
`default_nettype none

// one RAM bank on the nibble bus
// it keeps its own copy of the program and data pointers and only answers
// once it has been given a length and a base through the daisy chain
module nibble_ram_bank (
	input logic strobe,
	input logic rst_n,
	input nibble_bus_pkg::bus_cmd_t cmd,
	input logic daisy_in,
	output logic daisy_out,
	output nibble_bus_pkg::bank_resp_t resp
);
	import nibble_bus_pkg::*;
	import mem_sys_pkg::*;

	// configuration state, length comes first and the base second
	logic len_conf;
	logic addr_conf;
	logic configured;
	bus_addr_t base_addr;
	bus_len_t length;

	// every bank follows every broadcast, so these stay equal across banks
	bus_addr_t pc_ptr;
	bus_addr_t dp_ptr;

	nibble_t mem [BANK_DEPTH];

	logic is_pc;
	logic is_read;
	logic is_write;
	logic in_range;
	logic active;
	bus_addr_t acc_ptr;
	bus_addr_t offset;
	logic [BANK_ADDR_W-1:0] idx;

	logic hit_q;
	logic error_q;
	nibble_t rd_nibble;

	assign configured = len_conf & addr_conf;

	// the next bank in the chain may configure only after this one is done
	assign daisy_out = configured;

	always_comb begin
		is_pc = (cmd.op == PC_READ) || (cmd.op == PC_WRITE);
		is_read = (cmd.op == PC_READ) || (cmd.op == DP_READ);
		is_write = (cmd.op == PC_WRITE) || (cmd.op == DP_WRITE);
		acc_ptr = is_pc ? pc_ptr : dp_ptr;
		// the offset is only meaningful when the pointer is at or above the base
		offset = acc_ptr - base_addr;
		in_range = (acc_ptr >= base_addr) && ({1'b0, offset} < length);
		active = configured && (is_read || is_write) && in_range;
		// only 64 nibbles exist, a longer region wraps onto them
		idx = offset[BANK_ADDR_W-1:0];
	end

	always_ff @(posedge strobe or negedge rst_n) begin
		if (!rst_n) begin
			len_conf <= 1'b0;
			addr_conf <= 1'b0;
			base_addr <= '0;
			length <= '0;
			pc_ptr <= '0;
			dp_ptr <= '0;
			hit_q <= 1'b0;
			error_q <= 1'b0;
		end else begin
			// hit follows the command by one cycle and drops on anything else
			hit_q <= active;
			case (cmd.op)
			NOP: begin
			end
			// pointers advance on every access, hit or miss
			PC_READ, PC_WRITE: pc_ptr <= pc_ptr + 1'b1;
			DP_READ, DP_WRITE: dp_ptr <= dp_ptr + 1'b1;
			LOAD_PC: pc_ptr <= cmd.addr;
			LOAD_DP: dp_ptr <= cmd.addr;
			CONFIGURE: begin
				// the address of the first configure is the two's
				// complement of the size, the second one is the base
				if (!configured && daisy_in) begin
					if (!len_conf) begin
						length <= ADDR_SPACE - {1'b0, cmd.addr};
						len_conf <= 1'b1;
					end else begin
						base_addr <= cmd.addr;
						addr_conf <= 1'b1;
					end
				end
			end
			BUS_RESET: begin
				base_addr <= '0;
				length <= '0;
				len_conf <= 1'b0;
				addr_conf <= 1'b0;
			end
			default: begin
				// undefined code, stays flagged until rst_n
				error_q <= 1'b1;
			end
			endcase
		end
	end

	// storage and read data
	always_ff @(posedge strobe) begin
		if (active && is_write) begin
			mem[idx] <= cmd.nibble;
		end
		if (active && is_read) begin
			rd_nibble <= mem[idx];
		end
	end

	assign resp = '{hit: hit_q, nibble: rd_nibble, error: error_q};

endmodule

`default_nettype wire

//--- design/bank_response_merge.sv
`timescale 1ns/1ps
`default_nettype none

// folds the answers of all banks into the one response the bridge sees
// a properly configured map never has two banks hitting at the same time,
// conflict shows when the map overlaps
module bank_response_merge (
	input nibble_bus_pkg::bank_resp_t resp [mem_sys_pkg::NUM_BANKS],
	output nibble_bus_pkg::bank_resp_t merged,
	output logic conflict
);
	import nibble_bus_pkg::*;
	import mem_sys_pkg::*;

	logic hit_any;
	logic hit_multi;
	logic err_any;
	nibble_t nib_or;

	always_comb begin
		hit_any = 1'b0;
		hit_multi = 1'b0;
		err_any = 1'b0;
		nib_or = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			// a second hit on top of an earlier one is a conflict
			hit_multi = hit_multi | (hit_any & resp[i].hit);
			hit_any = hit_any | resp[i].hit;
			// banks that miss keep stale read data, so mask them out
			if (resp[i].hit) begin
				nib_or = nib_or | resp[i].nibble;
			end
			// error is taken from every bank, hit or not
			err_any = err_any | resp[i].error;
		end
	end

	assign merged = '{hit: hit_any, nibble: nib_or, error: err_any};
	assign conflict = hit_multi;

endmodule

`default_nettype wire

//--- design/nibble_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

// memory subsystem, Wishbone on the host side and a row of
// daisy-chained RAM banks on the nibble bus
module nibble_mem_top (
	input logic strobe,
	input logic rst_n,
	input logic cyc,
	input logic stb,
	input logic we,
	input mem_sys_pkg::host_reg_t adr,
	input logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic ack
);
	import nibble_bus_pkg::*;
	import mem_sys_pkg::*;

	bus_cmd_t cmd;
	bank_resp_t resp [NUM_BANKS];
	bank_resp_t merged;
	logic conflict;

	// daisy[k] enables bank k, the last link goes high once the whole row
	// is configured and is left for the testbench to observe
	logic [NUM_BANKS:0] daisy;

	// the first bank is always allowed to take a configure
	assign daisy[0] = 1'b1;

	wb_bus_bridge u_bridge (
		.strobe(strobe),
		.rst_n(rst_n),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.cmd(cmd),
		.merged(merged),
		.conflict(conflict)
	);

	// every bank sees the same broadcast command
	for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
		nibble_ram_bank u_bank (
			.strobe(strobe),
			.rst_n(rst_n),
			.cmd(cmd),
			.daisy_in(daisy[k]),
			.daisy_out(daisy[k+1]),
			.resp(resp[k])
		);
	end

	bank_response_merge u_merge (
		.resp(resp),
		.merged(merged),
		.conflict(conflict)
	);

endmodule

`default_nettype wire

//--- tb/nibble_mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the Wishbone port and on the broadcast nibble bus
module nibble_mem_checker (
	input logic strobe,
	input logic rst_n,
	input logic cyc,
	input logic stb,
	input logic ack,
	input nibble_bus_pkg::bus_cmd_t cmd,
	input logic conflict
);
	import nibble_bus_pkg::*;

	// running count of failed assertions
	int assert_fails = 0;

	// the slave only acknowledges a cycle that the host is still driving
	ack_in_cycle: assert property (@(posedge strobe) disable iff (!rst_n)
		ack |-> (cyc && stb))
	else begin
		$error("ack seen without cyc and stb");
		assert_fails++;
	end

	// a real command sits on the bus for a single cycle, then NOP returns
	cmd_one_cycle: assert property (@(posedge strobe) disable iff (!rst_n)
		(cmd.op != NOP) |=> (cmd.op == NOP))
	else begin
		$error("bus command held longer than one cycle");
		assert_fails++;
	end

	// the regions of the banks never overlap, so at most one bank hits
	no_conflict: assert property (@(posedge strobe) disable iff (!rst_n)
		!conflict)
	else begin
		$error("more than one bank answered");
		assert_fails++;
	end

endmodule

bind nibble_mem_top nibble_mem_checker chk_i (
	.strobe(strobe),
	.rst_n(rst_n),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.cmd(cmd),
	.conflict(conflict)
);

`default_nettype wire

//--- tb/nibble_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nibble_mem_tb;
	import nibble_bus_pkg::*;
	import mem_sys_pkg::*;

	// the tests need roughly 1000 cycles, every host command costs 4 to 10
	localparam int CYCLE_LIMIT = 4000;
	// size of the whole bus address map, pointers wrap here
	localparam int unsigned MAP_SIZE = 1 << 20;

	logic strobe;
	logic rst_n;
	logic cyc;
	logic stb;
	logic we;
	host_reg_t adr;
	logic [31:0] dat_w;
	logic [31:0] dat_r;
	logic ack;

	// reference model, stage counts the configure steps each bank has taken
	int unsigned m_pc;
	int unsigned m_dp;
	int m_stage [NUM_BANKS];
	int unsigned m_base [NUM_BANKS];
	int unsigned m_len [NUM_BANKS];
	logic [3:0] m_mem [NUM_BANKS][BANK_DEPTH];
	logic m_err;
	logic [31:0] m_status;

	// status reads waiting for the compare process
	logic [31:0] exp_q [$];
	logic [31:0] got_q [$];

	integer seed;
	int errors;
	int checks;
	int tests;
	int test_errors;
	int cycles;

	nibble_mem_top dut_i (
		.strobe(strobe),
		.rst_n(rst_n),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack)
	);

	always #5 strobe = ~strobe;

	always @(posedge strobe) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// each status read is split into its fields on a falling edge
	always @(negedge strobe) begin : compare_status
		logic [31:0] got;
		logic [31:0] exp;
		if (got_q.size() > 0) begin
			got = got_q.pop_front();
			exp = exp_q.pop_front();
			check_value("status.nibble", 32'(got[3:0]), 32'(exp[3:0]));
			check_value("status.hit", 32'(got[4]), 32'(exp[4]));
			check_value("status.conflict", 32'(got[5]), 32'(exp[5]));
			check_value("status.error", 32'(got[6]), 32'(exp[6]));
			check_value("status.upper", 32'(got[31:7]), 32'(exp[31:7]));
		end
	end

	// bank whose configured region holds ptr, or -1 when none does
	function automatic int hit_bank(input int unsigned ptr);
		int found;
		found = -1;
		for (int k = 0; k < NUM_BANKS; k++) begin
			if (m_stage[k] == 2 && ptr >= m_base[k] && ptr - m_base[k] < m_len[k]) begin
				found = k;
			end
		end
		return found;
	endfunction

	// the far end of the daisy chain is high only when every bank is configured
	function automatic logic chain_configured();
		logic done;
		done = 1'b1;
		for (int k = 0; k < NUM_BANKS; k++) begin
			if (m_stage[k] != 2) begin
				done = 1'b0;
			end
		end
		return done;
	endfunction

	// nibble, hit and error that a read through the chosen pointer returns
	function automatic logic [31:0] expected_status(input bit use_pc);
		int unsigned ptr;
		int k;
		logic [31:0] st;
		ptr = use_pc ? m_pc : m_dp;
		k = hit_bank(ptr);
		st = '0;
		st[6] = m_err;
		if (k >= 0) begin
			st[4] = 1'b1;
			st[3:0] = m_mem[k][(ptr - m_base[k]) % BANK_DEPTH];
		end
		return st;
	endfunction

	function automatic void update_model(input logic [3:0] op, input int unsigned addr,
			input logic [3:0] nib);
		int unsigned ptr;
		int k;
		int next;
		next = -1;
		case (op)
		NOP: begin
		end
		PC_READ, PC_WRITE, DP_READ, DP_WRITE: begin
			ptr = (op == PC_READ || op == PC_WRITE) ? m_pc : m_dp;
			k = hit_bank(ptr);
			if ((op == PC_WRITE || op == DP_WRITE) && k >= 0) begin
				m_mem[k][(ptr - m_base[k]) % BANK_DEPTH] = nib;
			end
			// the pointer used steps on every access, hit or miss
			if (op == PC_READ || op == PC_WRITE) begin
				m_pc = (ptr + 1) % MAP_SIZE;
			end else begin
				m_dp = (ptr + 1) % MAP_SIZE;
			end
		end
		LOAD_PC: m_pc = addr;
		LOAD_DP: m_dp = addr;
		CONFIGURE: begin
			// the chain enables only the lowest bank not yet configured
			for (int j = NUM_BANKS - 1; j >= 0; j--) begin
				if (m_stage[j] < 2) begin
					next = j;
				end
			end
			if (next >= 0 && m_stage[next] == 0) begin
				m_len[next] = MAP_SIZE - addr;
				m_stage[next] = 1;
			end else if (next >= 0) begin
				m_base[next] = addr;
				m_stage[next] = 2;
			end
		end
		BUS_RESET: begin
			for (int j = 0; j < NUM_BANKS; j++) begin
				m_stage[j] = 0;
			end
		end
		default: m_err = 1'b1;
		endcase
		// the bridge refreshes the status error bit after every command
		m_status[6] = m_err;
	endfunction

	// one Wishbone classic access, ack is sampled half a cycle after it is driven
	task automatic wb_cycle(input logic write, input host_reg_t reg_adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge strobe);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= write;
		adr <= reg_adr;
		dat_w <= wdata;
		do @(negedge strobe); while (!ack);
		rdata = dat_r;
		@(posedge strobe);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic wb_write(input logic [31:0] wdata);
		logic [31:0] unused;
		wb_cycle(1'b1, CMD_REG, wdata, unused);
	endtask

	task automatic wb_read(input host_reg_t reg_adr, output logic [31:0] rdata);
		wb_cycle(1'b0, reg_adr, 32'h0, rdata);
	endtask

	task automatic send_cmd(input logic [3:0] op, input int unsigned addr,
			input logic [3:0] nib);
		update_model(op, addr, nib);
		wb_write({4'b0, bus_addr_t'(addr), nib, op});
	endtask

	task automatic check_status();
		logic [31:0] got;
		wb_read(STATUS_REG, got);
		exp_q.push_back(m_status);
		got_q.push_back(got);
	endtask

	// the last daisy link is looked at mid-cycle, away from any register update
	task automatic check_chain_end();
		@(negedge strobe);
		check_value("daisy_out of last bank", 32'(dut_i.daisy[NUM_BANKS]),
			32'(chain_configured()));
	endtask

	task automatic read_ptr(input bit use_pc);
		m_status = expected_status(use_pc);
		send_cmd(use_pc ? PC_READ : DP_READ, 0, 4'h0);
		check_status();
	endtask

	task automatic read_region(input bit use_pc, input int unsigned start, input int n);
		send_cmd(use_pc ? LOAD_PC : LOAD_DP, start, 4'h0);
		repeat (n) read_ptr(use_pc);
	endtask

	// random nibbles written through DP from start onwards
	task automatic fill_region(input int unsigned start, input int n);
		send_cmd(LOAD_DP, start, 4'h0);
		repeat (n) send_cmd(DP_WRITE, 0, 4'($random(seed)));
	endtask

	// first configure carries the two's complement of the length, then the base
	task automatic configure(input int unsigned len, input int unsigned base);
		send_cmd(CONFIGURE, MAP_SIZE - len, 4'h0);
		send_cmd(CONFIGURE, base, 4'h0);
	endtask

	task automatic apply_reset();
		@(posedge strobe);
		rst_n <= 1'b0;
		repeat (5) @(posedge strobe);
		rst_n <= 1'b1;
		m_pc = 0;
		m_dp = 0;
		m_err = 1'b0;
		m_status = '0;
		for (int j = 0; j < NUM_BANKS; j++) begin
			m_stage[j] = 0;
		end
	endtask

	task automatic end_test(input string name);
		while (got_q.size() > 0) @(negedge strobe);
		tests++;
		if (errors == test_errors) begin
			$display("test %0d %s: passed", tests, name);
		end else begin
			$display("test %0d %s: %0d errors", tests, name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	initial begin
		strobe = 1'b0;
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = CMD_REG;
		dat_w = '0;
		seed = 32'h6847_412e;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errors = 0;
		cycles = 0;
		apply_reset();

		read_region(1'b1, 20'h00100, 2);
		read_region(1'b0, 20'h00000, 2);
		end_test("unconfigured banks are silent");

		configure(16, 20'h01000);
		check_chain_end();
		configure(64, 20'h02000);
		configure(100, 20'h03000);
		check_chain_end();
		fill_region(20'h01000, 8);
		fill_region(20'h02000, 8);
		fill_region(20'h03000, 8);
		read_region(1'b1, 20'h01000, 8);
		read_region(1'b1, 20'h02000, 8);
		read_region(1'b1, 20'h03000, 8);
		// below, between and above the three regions
		read_region(1'b1, 20'h00fff, 1);
		read_region(1'b1, 20'h01010, 1);
		read_region(1'b1, 20'h03064, 1);
		read_region(1'b1, 20'hf0000, 1);
		end_test("daisy chain configure and DP write, PC read");

		fill_region(20'h02014, 6);
		read_region(1'b1, 20'h02014, 6);
		// runs that step off the end of bank 0 and bank 1
		fill_region(20'h0100e, 2);
		read_region(1'b0, 20'h0100e, 3);
		fill_region(20'h0203e, 3);
		read_region(1'b1, 20'h0203e, 3);
		end_test("pointer increment and region end");

		send_cmd(BUS_RESET, 0, 4'h0);
		check_chain_end();
		read_region(1'b1, 20'h01000, 2);
		read_region(1'b0, 20'h02000, 2);
		configure(32, 20'h40000);
		configure(64, 20'h50000);
		configure(100, 20'h60000);
		check_chain_end();
		read_region(1'b1, 20'h40000, 8);
		read_region(1'b1, 20'h50014, 6);
		// offsets from 64 upwards fold back onto the first nibbles of bank 2
		read_region(1'b0, 20'h60040, 8);
		end_test("bus reset and reconfigure");

		check_status();
		send_cmd(4'hb, 0, 4'h0);
		check_status();
		send_cmd(LOAD_DP, 20'h50000, 4'h0);
		send_cmd(DP_WRITE, 0, 4'($random(seed)));
		read_region(1'b1, 20'h50000, 1);
		check_status();
		apply_reset();
		check_status();
		read_ptr(1'b1);
		end_test("sticky error flag");

		if (dut_i.chk_i.assert_fails != 0) begin
			$display("the protocol checker saw %0d assertion failures",
				dut_i.chk_i.assert_fails);
			errors += dut_i.chk_i.assert_fails;
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
design/nibble_bus_pkg.sv
design/mem_sys_pkg.sv
design/wb_bus_bridge.sv
design/nibble_ram_bank.sv
design/bank_response_merge.sv
design/nibble_mem_top.sv
tb/nibble_mem_checker.sv
tb/nibble_mem_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module nibble_mem_tb \
		-f all.f -Mdir obj_dir -o nibble_mem_sim
	./obj_dir/nibble_mem_sim | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
